// File: verilog/dns_filter_pkg.sv
// dns filter shared definitions
package dns_filter_pkg;

	// stream and lookup widths
	localparam int DATA_W = 64;
	localparam int KEEP_W = 8;
	localparam int KEY_W = 96;
	localparam int FLAG_W = 4;

	// beats held back while the verdict is pending
	localparam int DELAY_DEPTH = 12;

	// 64 beat output buffer
	localparam int FIFO_ADDR_W = 6;

	// protocol values, network byte order already undone
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0] IP_PROTO_UDP = 8'd17;
	localparam logic [15:0] DNS_PORT = 16'd53;

	// request flag for a DNS response
	localparam logic [FLAG_W-1:0] LOOKUP_OP_RESPONSE = 4'b0011;

	// verdict code in reply flag bits 2:1
	localparam logic [1:0] VERDICT_DROP = 2'b10;

	// one stream beat, 74 bits
	typedef struct packed {
		logic valid;
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic last;
	} axis_beat_t;

	// request towards the verdict table
	typedef struct packed {
		logic [KEY_W-1:0] key;
		logic [FLAG_W-1:0] flag;
	} lookup_req_t;

	// reply from the verdict table
	typedef struct packed {
		logic valid;
		logic [FLAG_W-1:0] flag;
	} lookup_rsp_t;

endpackage

// File: verilog/dns_header_parser.sv
// dns response header parser
`timescale 1ns/1ps

module dns_header_parser (
	input  logic clk156,
	input  logic eth_rst,
	input  dns_filter_pkg::axis_beat_t rx,
	output dns_filter_pkg::lookup_req_t lookup_req,
	output logic lookup_req_valid,
	output logic frame_start
);

	// beat position inside the frame, saturates past the header
	logic [3:0] beat_cnt;

	// fields that decide the frame class
	logic [15:0] eth_type;
	logic [7:0] ip_proto;
	logic [15:0] udp_src_port;
	logic [dns_filter_pkg::FLAG_W-1:0] req_flag;

	// fields that only feed the key
	logic [31:0] ip_src;
	logic [31:0] ip_dst;
	logic [15:0] udp_dst_port;
	logic [15:0] dns_flags;

	logic is_udp;
	logic suspect;

	assign is_udp = (eth_type == dns_filter_pkg::ETH_TYPE_IPV4) &&
		(ip_proto == dns_filter_pkg::IP_PROTO_UDP);
	assign suspect = is_udp && (udp_src_port == dns_filter_pkg::DNS_PORT);

	assign frame_start = rx.valid && (beat_cnt == 4'd0);

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			beat_cnt <= '0;
			eth_type <= '0;
			ip_proto <= '0;
			udp_src_port <= '0;
			req_flag <= '0;
		end else if (rx.valid) begin
			if (rx.last) begin
				beat_cnt <= '0;
			end else if (beat_cnt != 4'hf) begin
				beat_cnt <= beat_cnt + 4'd1;
			end

			case (beat_cnt)
				4'd0: begin
					eth_type <= '0;
					ip_proto <= '0;
					udp_src_port <= '0;
					req_flag <= '0;
				end
				// bytes 12-13
				4'd1: eth_type <= {rx.data[39:32], rx.data[47:40]};
				// byte 23
				4'd2: ip_proto <= rx.data[63:56];
				// bytes 34-35
				4'd4: begin
					if (is_udp) begin
						udp_src_port <= {rx.data[23:16], rx.data[31:24]};
					end
				end
				// QR bit decides response or query
				4'd6: begin
					if (suspect) begin
						req_flag <= dns_flags[15] ?
							dns_filter_pkg::LOOKUP_OP_RESPONSE : '0;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk156) begin
		if (rx.valid) begin
			case (beat_cnt)
				4'd0: begin
					ip_src <= '0;
					ip_dst <= '0;
					udp_dst_port <= '0;
					dns_flags <= '0;
				end
				// bytes 26-31
				4'd3: begin
					ip_src <= {rx.data[23:16], rx.data[31:24],
						rx.data[39:32], rx.data[47:40]};
					ip_dst[31:16] <= {rx.data[55:48], rx.data[63:56]};
				end
				// bytes 32-33 and 36-37
				4'd4: begin
					ip_dst[15:0] <= {rx.data[7:0], rx.data[15:8]};
					if (is_udp) begin
						udp_dst_port <= {rx.data[39:32], rx.data[47:40]};
					end
				end
				// dns flags word, bytes 44-45
				4'd5: begin
					if (suspect) begin
						dns_flags <= {rx.data[39:32], rx.data[47:40]};
					end
				end
				default: ;
			endcase
		end
	end

	// one request per suspect frame, alongside beat 7
	assign lookup_req_valid = rx.valid && suspect && (beat_cnt == 4'd7);

	assign lookup_req.key = {ip_src, ip_dst, udp_dst_port, 16'h0000};
	assign lookup_req.flag = req_flag;

endmodule

// File: verilog/frame_delay_line.sv
// verdict delay line
`timescale 1ns/1ps

module frame_delay_line (
	input  logic clk156,
	input  logic eth_rst,
	input  dns_filter_pkg::axis_beat_t rx,
	input  logic frame_start,
	input  dns_filter_pkg::lookup_rsp_t lookup_rsp,
	output dns_filter_pkg::axis_beat_t delayed
);

	dns_filter_pkg::axis_beat_t stage [dns_filter_pkg::DELAY_DEPTH];

	logic blocked;
	logic drop_now;
	logic blank;

	assign drop_now = lookup_rsp.valid &&
		(lookup_rsp.flag[2:1] == dns_filter_pkg::VERDICT_DROP);

	// blank at once on the reply, then hold until the next frame
	assign blank = blocked || drop_now;

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			blocked <= 1'b0;
		end else if (frame_start) begin
			blocked <= 1'b0;
		end else if (drop_now) begin
			blocked <= 1'b1;
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			for (int i = 0; i < dns_filter_pkg::DELAY_DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			// new frame beats keep entering
			stage[0] <= rx;
			for (int i = 1; i < dns_filter_pkg::DELAY_DEPTH; i++) begin
				stage[i] <= blank ? '0 : stage[i-1];
			end
		end
	end

	assign delayed = stage[dns_filter_pkg::DELAY_DEPTH-1];

endmodule

// File: verilog/tx_frame_fifo.sv
// transmit beat FIFO
`timescale 1ns/1ps

module tx_frame_fifo (
	input  logic clk156,
	input  logic eth_rst,
	input  dns_filter_pkg::axis_beat_t wr_beat,
	output dns_filter_pkg::axis_beat_t tx,
	input  logic tx_ready
);

	dns_filter_pkg::axis_beat_t mem [2**dns_filter_pkg::FIFO_ADDR_W];

	// extra msb tells full from empty
	logic [dns_filter_pkg::FIFO_ADDR_W:0] wr_ptr;
	logic [dns_filter_pkg::FIFO_ADDR_W:0] rd_ptr;

	logic wr_en;
	logic rd_en;
	logic empty;
	logic full;

	// no ready upstream, every valid beat is written
	assign wr_en = wr_beat.valid;
	assign rd_en = tx.valid && tx_ready;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[dns_filter_pkg::FIFO_ADDR_W-1:0] ==
		rd_ptr[dns_filter_pkg::FIFO_ADDR_W-1:0]) &&
		(wr_ptr[dns_filter_pkg::FIFO_ADDR_W] != rd_ptr[dns_filter_pkg::FIFO_ADDR_W]);

	always_ff @(posedge clk156) begin
		if (wr_en) begin
			mem[wr_ptr[dns_filter_pkg::FIFO_ADDR_W-1:0]] <= wr_beat;
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// head entry, valid comes from the pointers
	always_comb begin
		tx = mem[rd_ptr[dns_filter_pkg::FIFO_ADDR_W-1:0]];
		tx.valid = !empty;
	end

endmodule

// File: verilog/dns_filter_top.sv
// dns response filter top
`timescale 1ns/1ps

module dns_filter_top (
	input  logic clk156,
	input  logic eth_rst,
	input  dns_filter_pkg::axis_beat_t rx,
	output dns_filter_pkg::axis_beat_t tx,
	input  logic tx_ready,
	output dns_filter_pkg::lookup_req_t lookup_req,
	output logic lookup_req_valid,
	input  dns_filter_pkg::lookup_rsp_t lookup_rsp
);

	// parser to delay line
	logic frame_start;

	// delay line to FIFO
	dns_filter_pkg::axis_beat_t delayed;

	// header fields and lookup request
	dns_header_parser parser_i (
		.clk156           (clk156),
		.eth_rst          (eth_rst),
		.rx               (rx),
		.lookup_req       (lookup_req),
		.lookup_req_valid (lookup_req_valid),
		.frame_start      (frame_start)
	);

	// holds beats until the verdict is back
	frame_delay_line delay_i (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx          (rx),
		.frame_start (frame_start),
		.lookup_rsp  (lookup_rsp),
		.delayed     (delayed)
	);

	// absorbs tx back-pressure
	tx_frame_fifo fifo_i (
		.clk156   (clk156),
		.eth_rst  (eth_rst),
		.wr_beat  (delayed),
		.tx       (tx),
		.tx_ready (tx_ready)
	);

endmodule

// File: verification/tb_clock_gen.sv
// clock and reset source
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk156,
	output logic eth_rst
);

	// 4 ns period
	initial begin
		clk156 = 1'b0;
		forever #2 clk156 = ~clk156;
	end

	// reset held for five rising edges
	initial begin
		eth_rst = 1'b1;
		repeat (5) @(posedge clk156);
		eth_rst <= 1'b0;
	end

endmodule

// File: verification/dns_filter_properties.sv
// dns filter assertions
`timescale 1ns/1ps

module dns_filter_properties (
	input logic clk156,
	input logic eth_rst,
	input logic fifo_wr,
	input logic fifo_full,
	input logic tx_valid,
	input logic lookup_req_valid
);

	// count of failed assertions
	int failures = 0;

	// no upstream ready, a write into a full FIFO loses a beat
	no_write_when_full: assert property (@(posedge clk156) disable iff (eth_rst)
		!(fifo_wr && fifo_full))
	else begin
		$error("FIFO written while full");
		failures++;
	end

	tx_idle_in_reset: assert property (@(posedge clk156) eth_rst |=> !tx_valid)
	else begin
		$error("tx valid high during or right after reset");
		failures++;
	end

	// one request per suspect frame
	single_req_pulse: assert property (@(posedge clk156) disable iff (eth_rst)
		lookup_req_valid |=> !lookup_req_valid)
	else begin
		$error("lookup_req_valid high on two consecutive cycles");
		failures++;
	end

endmodule

bind dns_filter_top dns_filter_properties props_i (
	.clk156           (clk156),
	.eth_rst          (eth_rst),
	.fifo_wr          (fifo_i.wr_en),
	.fifo_full        (fifo_i.full),
	.tx_valid         (tx.valid),
	.lookup_req_valid (lookup_req_valid)
);

// File: verification/dns_filter_tb.sv
// dns filter testbench
`timescale 1ns/1ps

module dns_filter_tb;

	localparam logic [31:0] SEED = 32'he2b3efaf;
	localparam int NUM_FRAMES = 200;
	localparam int MIN_BEATS = 8;
	localparam int MAX_BEATS = 16;
	localparam int GAP_EXTRA = 6;
	localparam int WAIT_LIMIT = 4000;

	logic clk156;
	logic eth_rst;
	logic tx_ready;
	logic lookup_req_valid;
	logic was_reset = 1'b0;
	dns_filter_pkg::axis_beat_t rx;
	dns_filter_pkg::axis_beat_t tx;
	dns_filter_pkg::lookup_req_t lookup_req;
	dns_filter_pkg::lookup_rsp_t lookup_rsp = '0;

	// reference model, filled as each frame is built
	dns_filter_pkg::axis_beat_t exp_beats [$];
	dns_filter_pkg::lookup_req_t exp_reqs [$];
	logic [dns_filter_pkg::FLAG_W-1:0] verdicts [$];

	int mismatches = 0;
	int other_errors = 0;

	tb_clock_gen clk_gen_i (
		.clk156  (clk156),
		.eth_rst (eth_rst)
	);

	dns_filter_top dut_i (
		.clk156           (clk156),
		.eth_rst          (eth_rst),
		.rx               (rx),
		.tx               (tx),
		.tx_ready         (tx_ready),
		.lookup_req       (lookup_req),
		.lookup_req_valid (lookup_req_valid),
		.lookup_rsp       (lookup_rsp)
	);

	task automatic report_mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		mismatches++;
		$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout waiting for %s at %0t", what, $time);
		$display("TEST FAILED");
		$finish;
	endtask

	// one clock, tx ready low about one cycle in four
	task automatic step_cycle();
		@(posedge clk156);
		tx_ready <= ($urandom_range(3) != 0);
	endtask

	// kinds 0 and 1 are DNS response and query, 2 other UDP, 3 non-IP from port 53
	task automatic send_frame(input int kind);
		logic [7:0] bytes [MAX_BEATS*8];
		dns_filter_pkg::axis_beat_t beats [$];
		dns_filter_pkg::axis_beat_t beat;
		logic [dns_filter_pkg::FLAG_W-1:0] verdict;
		int nbeats;
		bit dropped;

		nbeats = $urandom_range(MAX_BEATS, MIN_BEATS);
		foreach (bytes[i]) begin
			bytes[i] = 8'($urandom);
		end
		{bytes[12], bytes[13], bytes[23]} =
			{dns_filter_pkg::ETH_TYPE_IPV4, dns_filter_pkg::IP_PROTO_UDP};
		{bytes[34], bytes[35]} = (kind != 2) ? dns_filter_pkg::DNS_PORT : {1'b1, 15'($urandom)};
		bytes[44][7] = (kind == 0);
		if (kind == 3) begin
			bytes[12][4] = 1'b1;
		end
		verdict = 4'($urandom);
		dropped = (kind < 2) && (verdict[2:1] == dns_filter_pkg::VERDICT_DROP);
		if (kind < 2) begin
			exp_reqs.push_back({bytes[26], bytes[27], bytes[28], bytes[29], bytes[30],
				bytes[31], bytes[32], bytes[33], bytes[36], bytes[37], 16'h0000,
				(kind == 0) ? dns_filter_pkg::LOOKUP_OP_RESPONSE : 4'b0000});
			verdicts.push_back(verdict);
		end
		for (int b = 0; b < nbeats; b++) begin
			beat.valid = 1'b1;
			beat.last = (b == nbeats - 1);
			beat.keep = beat.last ? (8'hff >> $urandom_range(7)) : 8'hff;
			for (int j = 0; j < 8; j++) begin
				beat.data[8*j +: 8] = bytes[8*b + j];
			end
			beats.push_back(beat);
			if (!dropped)
				exp_beats.push_back(beat);
		end
		foreach (beats[b]) begin
			step_cycle();
			rx <= beats[b];
		end
		// idle gap longer than the delay line
		repeat (dns_filter_pkg::DELAY_DEPTH + $urandom_range(GAP_EXTRA)) begin
			step_cycle();
			rx <= '0;
		end
	endtask

	// verdict table, answers each request on the next cycle
	always @(posedge clk156) begin
		dns_filter_pkg::lookup_req_t expected;
		lookup_rsp <= '0;
		if (lookup_req_valid === 1'b1) begin
			if (exp_reqs.size() == 0) begin
				other_errors++;
				$display("lookup request at %0t from a frame that is no DNS candidate", $time);
			end else begin
				expected = exp_reqs.pop_front();
				if (lookup_req.key !== expected.key)
					report_mismatch("lookup_req.key", expected.key, lookup_req.key);
				if (lookup_req.flag !== expected.flag)
					report_mismatch("lookup_req.flag", expected.flag, lookup_req.flag);
				lookup_rsp <= {1'b1, verdicts.pop_front()};
			end
		end
	end

	// reset outputs and transmitted beats
	always @(posedge clk156) begin
		dns_filter_pkg::axis_beat_t expected;
		if (was_reset && tx.valid !== 1'b0)
			report_mismatch("tx.valid", 0, tx.valid);
		if (was_reset && lookup_req_valid !== 1'b0)
			report_mismatch("lookup_req_valid", 0, lookup_req_valid);
		was_reset = eth_rst;
		if (!eth_rst && tx.valid === 1'b1 && tx_ready === 1'b1) begin
			if (exp_beats.size() == 0) begin
				other_errors++;
				$display("beat on tx at %0t that no passing frame accounts for", $time);
			end else begin
				expected = exp_beats.pop_front();
				if (tx.data !== expected.data)
					report_mismatch("tx.data", expected.data, tx.data);
				if (tx.keep !== expected.keep)
					report_mismatch("tx.keep", expected.keep, tx.keep);
				if (tx.last !== expected.last)
					report_mismatch("tx.last", expected.last, tx.last);
			end
		end
	end

	initial begin
		int cnt;
		void'($urandom(SEED));
		rx = '0;
		tx_ready = 1'b0;
		cnt = 0;
		while (eth_rst !== 1'b0) begin
			step_cycle();
			cnt++;
			if (cnt > 50)
				stop_on_timeout("reset release");
		end
		repeat (4) step_cycle();
		for (int f = 0; f < NUM_FRAMES; f++) begin
			send_frame($urandom_range(3));
		end
		cnt = 0;
		while (exp_beats.size() != 0) begin
			step_cycle();
			cnt++;
			if (cnt > WAIT_LIMIT)
				stop_on_timeout("the remaining beats on tx");
		end
		// window for stray beats
		repeat (32) step_cycle();
		if (exp_reqs.size() != 0) begin
			other_errors++;
			$display("%0d expected lookup requests never arrived", exp_reqs.size());
		end
		$display("errors: %0d mismatches, %0d other, %0d assertion failures",
			mismatches, other_errors, dut_i.props_i.failures);
		if (mismatches + other_errors + dut_i.props_i.failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: all.f
verilog/dns_filter_pkg.sv
verilog/dns_header_parser.sv
verilog/frame_delay_line.sv
verilog/tx_frame_fifo.sv
verilog/dns_filter_top.sv
verification/tb_clock_gen.sv
verification/dns_filter_properties.sv
verification/dns_filter_tb.sv
